/* verilog/link_cfg_pkg.sv */
package link_cfg_pkg;

  // width of one link word in bits
  localparam int width_c = 32;

  // the receiver buffers 2^lg_fifo_depth_c words
  localparam int lg_fifo_depth_c = 3;

  // every token edge is worth 2^lg_credit_to_token_decimation_c credits
  localparam int lg_credit_to_token_decimation_c = 0;

  // the sender starts with one credit per receiver entry
  localparam int fifo_depth_c = 2 ** lg_fifo_depth_c;

  // a credit tally runs from zero up to fifo_depth_c inclusive
  localparam int credit_width_c = lg_fifo_depth_c + 1;

  // with the receiver stalled the sender buffer holds two more words
  localparam int max_in_flight_c = fifo_depth_c + 2;

endpackage

/* verilog/link_flit_pkg.sv */
package link_flit_pkg;

  // one word as it travels from the core through the link and back out
  typedef logic [link_cfg_pkg::width_c-1:0] flit_t;

  // wide enough for the largest credit tally the link can build up
  typedef logic [link_cfg_pkg::credit_width_c-1:0] credit_cnt_t;

endpackage

/* verilog/link_two_fifo.sv */
module link_two_fifo
  #(parameter width_p = 32
  )
  (input  logic                io_clk_i
  ,input  logic                arst_n_i
  // enqueue side with valid/ready handshake
  ,input  logic                v_i
  ,input  link_flit_pkg::flit_t data_i
  ,output logic                ready_o
  // dequeue side where the consumer yumis a valid head
  ,output logic                v_o
  ,output link_flit_pkg::flit_t data_o
  ,input  logic                yumi_i
  );

  // two storage slots addressed by one bit pointers
  logic [width_p-1:0] mem_r [2];
  logic               wr_ptr_r;
  logic               rd_ptr_r;
  logic               full_r;
  logic               empty_r;
  logic               enq;

  // ready only depends on the full flag so the core never waits on credit logic
  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ~full_r;

  always_ff @(posedge io_clk_i)
  begin
    if (enq)
    begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge io_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (enq)
      begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (yumi_i)
      begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // a write without a read fills the buffer when the writer catches the reader
      if (enq & ~yumi_i)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wr_ptr_r == rd_ptr_r);
      end
      // a read without a write empties it when the reader catches the writer
      else if (yumi_i & ~enq)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rd_ptr_r == wr_ptr_r);
      end
    end
  end

endmodule

/* verilog/link_async_credit_counter.sv */
module link_async_credit_counter
  #(parameter max_tokens_p                    = 4
  ,parameter lg_credit_to_token_decimation_p = 0
  ,parameter count_negedge_p                 = 0
  )
  (// the token line itself clocks the write side
   input  logic w_clk_i
  ,input  logic arst_n_i
  // the io clock domain keeps the credit tally
  ,input  logic r_clk_i
  ,input  logic r_dec_credit_i
  ,output logic r_credits_avail_o
  );

  // spent credits are counted at credit granularity in a full tally word
  localparam int spent_width_lp = $bits(link_flit_pkg::credit_cnt_t);
  // returned tokens drop the decimation bits of that word
  localparam int tok_width_lp   = spent_width_lp - lg_credit_to_token_decimation_p;

  // converts a synchronized gray count back to binary with a prefix xor
  function automatic logic [tok_width_lp-1:0] gray_to_bin
    (input logic [tok_width_lp-1:0] gray);
    logic [tok_width_lp-1:0] bin;
    for (int i = 0; i < tok_width_lp; i++)
    begin
      bin[i] = ^(gray >> i);
    end
    return bin;
  endfunction

  logic [tok_width_lp-1:0]     w_bin_r;
  logic [tok_width_lp-1:0]     w_gray_r;
  logic [tok_width_lp-1:0]     w_bin_n;
  logic [tok_width_lp-1:0]     r_gray_s1_r;
  logic [tok_width_lp-1:0]     r_gray_s2_r;
  logic [tok_width_lp-1:0]     r_tokens;
  logic [tok_width_lp-1:0]     r_spent_tokens;
  logic [tok_width_lp-1:0]     r_owed;
  link_flit_pkg::credit_cnt_t  r_spent_r;

  assign w_bin_n = w_bin_r + 1'b1;

  // every token edge of the selected polarity returns one token
  // the gray copy is launched from its own flop so the crossing stays clean
  if (count_negedge_p == 0)
  begin : g_posedge
    always_ff @(posedge w_clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        w_bin_r  <= '0;
        w_gray_r <= '0;
      end
      else
      begin
        w_bin_r  <= w_bin_n;
        w_gray_r <= w_bin_n ^ (w_bin_n >> 1);
      end
    end
  end
  else
  begin : g_negedge
    always_ff @(negedge w_clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        w_bin_r  <= '0;
        w_gray_r <= '0;
      end
      else
      begin
        w_bin_r  <= w_bin_n;
        w_gray_r <= w_bin_n ^ (w_bin_n >> 1);
      end
    end
  end

  // two flop synchronizer into the io domain plus the spent credit counter
  always_ff @(posedge r_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      r_gray_s1_r <= '0;
      r_gray_s2_r <= '0;
      r_spent_r   <= '0;
    end
    else
    begin
      r_gray_s1_r <= w_gray_r;
      r_gray_s2_r <= r_gray_s1_r;
      if (r_dec_credit_i)
      begin
        r_spent_r <= r_spent_r + 1'b1;
      end
    end
  end

  assign r_tokens       = gray_to_bin(r_gray_s2_r);
  // a token is only used up once all its decimated credits are spent
  assign r_spent_tokens = r_spent_r[spent_width_lp-1:lg_credit_to_token_decimation_p];
  // tokens taken but not yet returned, modulo the counter width
  assign r_owed         = r_spent_tokens - r_tokens;

  // the counter starts full so max_tokens_p may be outstanding at once
  assign r_credits_avail_o = (r_owed < tok_width_lp'(max_tokens_p));

endmodule

/* verilog/link_upstream_sync.sv */
module link_upstream_sync
  #(parameter width_p                         = 32
  ,parameter lg_fifo_depth_p                 = 3
  ,parameter lg_credit_to_token_decimation_p = 0
  )
  (input  logic                io_clk_i
  ,input  logic                arst_n_i
  // words coming from the core
  ,input  logic                io_v_i
  ,input  link_flit_pkg::flit_t io_data_i
  ,output logic                io_ready_and_o
  // words going onto the link, and the returning token line
  ,output logic                io_v_o
  ,output link_flit_pkg::flit_t io_data_o
  ,input  logic                token_clk_i
  );

  // half of the receiver depth is covered by each token edge polarity
  localparam int max_tokens_lp = 2 ** (lg_fifo_depth_p - 1 - lg_credit_to_token_decimation_p);

  logic                                   fifo_v;
  link_flit_pkg::flit_t                   fifo_data;
  logic                                   send;
  logic [lg_credit_to_token_decimation_p:0] alt_r;
  logic                                   on_negedge;
  logic                                   pos_avail;
  logic                                   neg_avail;
  logic                                   credit_avail;

  // the buffer keeps the credit compare off the core's input timing path
  link_two_fifo
    #(.width_p(width_p)
    ) u_two_fifo
    (.io_clk_i(io_clk_i)
    ,.arst_n_i(arst_n_i)
    ,.v_i     (io_v_i)
    ,.data_i  (io_data_i)
    ,.ready_o (io_ready_and_o)
    ,.v_o     (fifo_v)
    ,.data_o  (fifo_data)
    ,.yumi_i  (send)
    );

  // 2^decimation sends draw on posedge credit, then as many on negedge credit
  // the receiver returns token edges in that same alternating order
  always_ff @(posedge io_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      alt_r <= '0;
    end
    else if (send)
    begin
      alt_r <= alt_r + 1'b1;
    end
  end

  assign on_negedge   = alt_r[lg_credit_to_token_decimation_p];
  assign credit_avail = on_negedge ? neg_avail : pos_avail;

  // a word leaves as soon as the head is valid and the current edge has credit
  assign send      = fifo_v & credit_avail;
  assign io_v_o    = send;
  assign io_data_o = send ? fifo_data : '0;

  // rising token edges refill this one
  link_async_credit_counter
    #(.max_tokens_p                   (max_tokens_lp)
    ,.lg_credit_to_token_decimation_p(lg_credit_to_token_decimation_p)
    ,.count_negedge_p                (0)
    ) u_pos_credit
    (.w_clk_i          (token_clk_i)
    ,.arst_n_i         (arst_n_i)
    ,.r_clk_i          (io_clk_i)
    ,.r_dec_credit_i   (send & ~on_negedge)
    ,.r_credits_avail_o(pos_avail)
    );

  // falling token edges refill this one
  link_async_credit_counter
    #(.max_tokens_p                   (max_tokens_lp)
    ,.lg_credit_to_token_decimation_p(lg_credit_to_token_decimation_p)
    ,.count_negedge_p                (1)
    ) u_neg_credit
    (.w_clk_i          (token_clk_i)
    ,.arst_n_i         (arst_n_i)
    ,.r_clk_i          (io_clk_i)
    ,.r_dec_credit_i   (send & on_negedge)
    ,.r_credits_avail_o(neg_avail)
    );

endmodule

/* verilog/link_downstream_sync.sv */
module link_downstream_sync
  #(parameter width_p                         = 32
  ,parameter lg_fifo_depth_p                 = 3
  ,parameter lg_credit_to_token_decimation_p = 0
  )
  (input  logic                io_clk_i
  ,input  logic                arst_n_i
  // words arriving from the link, there is no ready since credits guarantee space
  ,input  logic                io_v_i
  ,input  link_flit_pkg::flit_t io_data_i
  // words handed to the core
  ,output logic                io_v_o
  ,output link_flit_pkg::flit_t io_data_o
  ,input  logic                io_ready_and_i
  // token line returned to the sender
  ,output logic                token_o
  );

  localparam int depth_lp = 2 ** lg_fifo_depth_p;

  // pointers carry one extra bit to tell a full buffer from an empty one
  logic [width_p-1:0]       mem_r [depth_lp];
  logic [lg_fifo_depth_p:0] wr_ptr_r;
  logic [lg_fifo_depth_p:0] rd_ptr_r;
  logic                     deq;
  logic                     token_step;
  logic                     token_r;

  assign io_v_o    = (wr_ptr_r != rd_ptr_r);
  assign io_data_o = mem_r[rd_ptr_r[lg_fifo_depth_p-1:0]];
  assign deq       = io_v_o & io_ready_and_i;
  assign token_o   = token_r;

  always_ff @(posedge io_clk_i)
  begin
    if (io_v_i)
    begin
      mem_r[wr_ptr_r[lg_fifo_depth_p-1:0]] <= io_data_i;
    end
  end

  always_ff @(posedge io_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end
    else
    begin
      if (io_v_i)
      begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (deq)
      begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  // without decimation every drained word returns one token edge
  if (lg_credit_to_token_decimation_p == 0)
  begin : g_no_decimation
    assign token_step = deq;
  end
  else
  begin : g_decimation
    logic [lg_credit_to_token_decimation_p-1:0] deq_cnt_r;

    always_ff @(posedge io_clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        deq_cnt_r <= '0;
      end
      else if (deq)
      begin
        deq_cnt_r <= deq_cnt_r + 1'b1;
      end
    end

    // the edge goes out when the counter wraps on the last word of a group
    assign token_step = deq & (&deq_cnt_r);
  end

  // the token leaves from a flop because the sender uses it as a clock
  always_ff @(posedge io_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      token_r <= 1'b0;
    end
    else if (token_step)
    begin
      token_r <= ~token_r;
    end
  end

endmodule

/* verilog/link_loopback_top.sv */
module link_loopback_top
  #(parameter width_p                         = link_cfg_pkg::width_c
  ,parameter lg_fifo_depth_p                 = link_cfg_pkg::lg_fifo_depth_c
  ,parameter lg_credit_to_token_decimation_p = link_cfg_pkg::lg_credit_to_token_decimation_c
  )
  (input  logic               io_clk_i
  ,input  logic               arst_n_i
  // core side feeding the sender
  ,input  logic               core_v_i
  ,input  logic [width_p-1:0] core_data_i
  ,output logic               core_ready_and_o
  // core side draining the receiver
  ,output logic               core_v_o
  ,output logic [width_p-1:0] core_data_o
  ,input  logic               core_ready_and_i
  );

  // the phy is just these wires, only the token line crosses as a clock
  logic                 link_v;
  link_flit_pkg::flit_t link_data;
  logic                 link_token;

  link_upstream_sync
    #(.width_p                        (width_p)
    ,.lg_fifo_depth_p                (lg_fifo_depth_p)
    ,.lg_credit_to_token_decimation_p(lg_credit_to_token_decimation_p)
    ) u_upstream
    (.io_clk_i      (io_clk_i)
    ,.arst_n_i      (arst_n_i)
    ,.io_v_i        (core_v_i)
    ,.io_data_i     (core_data_i)
    ,.io_ready_and_o(core_ready_and_o)
    ,.io_v_o        (link_v)
    ,.io_data_o     (link_data)
    ,.token_clk_i   (link_token)
    );

  link_downstream_sync
    #(.width_p                        (width_p)
    ,.lg_fifo_depth_p                (lg_fifo_depth_p)
    ,.lg_credit_to_token_decimation_p(lg_credit_to_token_decimation_p)
    ) u_downstream
    (.io_clk_i      (io_clk_i)
    ,.arst_n_i      (arst_n_i)
    ,.io_v_i        (link_v)
    ,.io_data_i     (link_data)
    ,.io_v_o        (core_v_o)
    ,.io_data_o     (core_data_o)
    ,.io_ready_and_i(core_ready_and_i)
    ,.token_o       (link_token)
    );

endmodule

/* test/link_clk_gen.sv */
module link_clk_gen
  (output logic clk_o
  ,output logic arst_n_o
  );

  // free running io clock with a period of 8 time units
  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #4 clk_o = ~clk_o;
    end
  end

  // reset is held for the first 8 rising edges and released on an edge
  initial
  begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

/* test/link_tb.sv */
module link_tb;

  logic                 clk;
  logic                 arst_n;
  // inputs of the DUT, driven on the rising edge
  logic                 in_v;
  link_flit_pkg::flit_t in_data;
  logic                 out_ready;
  // outputs of the DUT, sampled on the falling edge where they are stable
  logic                 in_ready;
  logic                 out_v;
  link_flit_pkg::flit_t out_data;

  // every accepted word waits here until it shows up at the receiver output
  link_flit_pkg::flit_t model_q[$];
  logic [31:0]          rand_state;
  int                   in_cnt = 0;
  int                   out_cnt = 0;
  int                   checks = 0;
  int                   errors = 0;
  // high when the word on offer goes into the sender at the coming rising edge
  logic                 offer_taken = 1'b0;

  link_clk_gen u_clk_gen
    (.clk_o   (clk)
    ,.arst_n_o(arst_n)
    );

  link_loopback_top
    #(.width_p                        (link_cfg_pkg::width_c)
    ,.lg_fifo_depth_p                (link_cfg_pkg::lg_fifo_depth_c)
    ,.lg_credit_to_token_decimation_p(link_cfg_pkg::lg_credit_to_token_decimation_c)
    ) u_dut
    (.io_clk_i        (clk)
    ,.arst_n_i        (arst_n)
    ,.core_v_i        (in_v)
    ,.core_data_i     (in_data)
    ,.core_ready_and_o(in_ready)
    ,.core_v_o        (out_v)
    ,.core_data_o     (out_data)
    ,.core_ready_and_i(out_ready)
    );

  // the low bits of this linear congruential step repeat quickly so callers shift them away
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // true with a probability of pct percent
  function automatic logic chance(input int unsigned pct);
    return ((next_rand() >> 8) % 32'd100) < pct;
  endfunction

  task automatic check_flit(input link_flit_pkg::flit_t got, input link_flit_pkg::flit_t exp,
                            input string what);
    checks++;
    if (got !== exp)
    begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input link_flit_pkg::credit_cnt_t got,
                             input link_flit_pkg::credit_cnt_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
    begin
      $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // records the handshakes that complete at the next rising edge
  task automatic sample_outputs();
    link_flit_pkg::flit_t exp;
    offer_taken = in_v & in_ready;
    if (offer_taken)
    begin
      model_q.push_back(in_data);
      in_cnt++;
    end
    if (out_v && out_ready)
    begin
      if (model_q.size() == 0)
      begin
        $display("a word came out at time %0t although none was outstanding", $time);
        errors++;
      end
      else
      begin
        exp = model_q.pop_front();
        check_flit(out_data, exp, "core_data_o");
      end
      out_cnt++;
    end
  endtask

  task automatic check_reset();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!arst_n && cycles < 50)
    begin
      check_flag(out_v, 1'b0, "core_v_o in reset");
      check_flag(in_ready, 1'b1, "core_ready_and_o in reset");
      cycles++;
      @(negedge clk);
    end
    if (!arst_n)
    begin
      $display("reset was still asserted after %0d cycles", cycles);
      errors++;
    end
    else
    begin
      // first falling edge with reset released
      check_flag(out_v, 1'b0, "core_v_o after reset");
      check_flag(in_ready, 1'b1, "core_ready_and_o after reset");
    end
  endtask

  // random valid and ready until n_words went in and came back out
  task automatic run_traffic(input int n_words, input int unsigned v_pct,
                             input int unsigned rdy_pct, input int max_cycles);
    int in_goal;
    int out_goal;
    int cycles;
    in_goal  = in_cnt + n_words;
    out_goal = out_cnt + n_words;
    cycles   = 0;
    while (out_cnt < out_goal && cycles < max_cycles)
    begin
      @(posedge clk);
      // a word that was not taken stays on offer with the same data
      if (!in_v || offer_taken)
      begin
        if (in_cnt < in_goal && chance(v_pct))
        begin
          in_v    <= 1'b1;
          in_data <= next_rand();
        end
        else
        begin
          in_v <= 1'b0;
        end
      end
      out_ready <= chance(rdy_pct);
      @(negedge clk);
      sample_outputs();
      cycles++;
    end
    if (out_cnt < out_goal)
    begin
      $display("timed out after %0d cycles with %0d of %0d words received",
               cycles, n_words - (out_goal - out_cnt), n_words);
      errors++;
    end
  endtask

  // one cycle of offering words into a stalled receiver
  task automatic stall_cycle();
    @(posedge clk);
    out_ready <= 1'b0;
    if (!in_v || offer_taken)
    begin
      in_v    <= 1'b1;
      in_data <= next_rand();
    end
    @(negedge clk);
    sample_outputs();
  endtask

  task automatic stall_fill();
    int                         start;
    int                         cycles;
    link_flit_pkg::credit_cnt_t held;
    start  = in_cnt;
    cycles = 0;
    // credits run out, then the two entry buffer fills and ready drops
    do
    begin
      stall_cycle();
      cycles++;
    end
    while (in_ready && cycles < 200);
    if (in_ready)
    begin
      $display("core_ready_and_o never dropped while the receiver was stalled");
      errors++;
    end
    // ready must stay low for a while with valid still high
    repeat (24)
    begin
      stall_cycle();
      check_flag(in_ready, 1'b0, "core_ready_and_o while stalled");
    end
    held = link_flit_pkg::credit_cnt_t'(in_cnt - start);
    check_count(held, link_flit_pkg::credit_cnt_t'(link_cfg_pkg::max_in_flight_c),
                "words accepted while stalled");
  endtask

  task automatic drain_recover();
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge clk);
      out_ready <= 1'b1;
      // the pending word is withdrawn only once the sender took it
      if (offer_taken)
      begin
        in_v <= 1'b0;
      end
      @(negedge clk);
      sample_outputs();
      cycles++;
    end
    while ((model_q.size() != 0 || in_v || !in_ready) && cycles < 200);
    if (model_q.size() != 0 || in_v || !in_ready)
    begin
      $display("the stalled words did not drain within %0d cycles", cycles);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_mark);
    $display("%s finished with %0d errors", name, errors - err_mark);
  endtask

  initial
  begin
    int err_mark;
    rand_state = 32'hf08f140a;
    in_v       = 1'b0;
    in_data    = '0;
    out_ready  = 1'b0;

    err_mark = errors;
    check_reset();
    report_test("reset_state", err_mark);

    err_mark = errors;
    run_traffic(300, 70, 60, 300 * 30);
    report_test("order_integrity", err_mark);

    err_mark = errors;
    stall_fill();
    report_test("credit_bound", err_mark);

    err_mark = errors;
    drain_recover();
    report_test("recovery", err_mark);

    // heavy offer against a slow drain so both token edges keep cycling
    err_mark = errors;
    run_traffic(25 * link_cfg_pkg::fifo_depth_c, 90, 40, 200 * 40);
    report_test("credit_recycling", err_mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/link_cfg_pkg.sv
verilog/link_flit_pkg.sv
verilog/link_two_fifo.sv
verilog/link_async_credit_counter.sv
verilog/link_upstream_sync.sv
verilog/link_downstream_sync.sv
verilog/link_loopback_top.sv
test/link_clk_gen.sv
test/link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the loopback testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module link_tb \
  -Mdir obj_dir > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vlink_tb > sim.log 2>&1 \
  || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -qx "test passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }
